/* rtl/aprPkg.sv */
package aprPkg;

  // Command data word from the condition bus
  typedef logic [17:0] aprDataT;

  // One bit per event flag in the order of the mask bits of aprDataT
  typedef logic [7:0] aprFlagsT;

  typedef logic [2:0] aprBlockT;
  typedef logic [3:0] aprAcT;

  // Block in the upper bits and AC in the lower
  typedef logic [6:0] aprFmAddrT;

  typedef logic [1:0] aprDiagSelT;

  // Flag positions with their own meaning in the logic
  localparam int flagNxm = 1;
  localparam int flagMemPar = 3;
  localparam int flagAdrPar = 5;
  localparam int flagSweepDone = 7;

  // Block fields inside the data word
  localparam int dataCurBlockLsb = 8;
  localparam int dataPrevBlockLsb = 11;

  // Fast-memory address sources in microcode field order
  typedef enum logic [2:0] {
    fmAc,
    fmAcPlus1,
    fmXr,
    fmVma,
    fmAcPlus2,
    fmAcPlus3,
    fmAcPlusMagic,
    fmMagic
  } aprFmSelT;

  // Codes 6 and 7 are spare and decode to nothing
  typedef enum logic [2:0] {
    condSelEn,
    condSelDis,
    condSelSet,
    condSelClr,
    condLoadBlocks,
    condReadDiag
  } aprCondT;

  typedef struct packed {
    logic    selEn;
    logic    selDis;
    logic    selSet;
    logic    selClr;
    logic    loadBlocks;
    logic    readDiag;
    aprDataT data;
  } aprCmdT;

endpackage

/* rtl/aprCommandDecode.sv */
`timescale 1ns/100ps

module aprCommandDecode (
  input  logic               clk,
  input  logic               reset,
  input  logic               condStrobe,
  input  aprPkg::aprCondT    condCode,
  input  aprPkg::aprDataT    condData,
  input  aprPkg::aprDiagSelT diagSel,
  output aprPkg::aprCmdT     cmd,
  output aprPkg::aprDiagSelT diagSelReg
);

  logic               strobeQ;
  aprPkg::aprCondT    codeQ;
  aprPkg::aprDataT    dataQ;
  aprPkg::aprDiagSelT diagSelQ;
  aprPkg::aprCmdT     cmdNext;
  logic [5:0]         strobes;

  // First stage captures the bus as it stands
  always_ff @(posedge clk) begin
    if (reset) begin
      strobeQ <= 1'b0;
    end else begin
      strobeQ <= condStrobe;
    end
  end

  always_ff @(posedge clk) begin
    codeQ    <= condCode;
    dataQ    <= condData;
    diagSelQ <= diagSel;
  end

  always_comb begin
    cmdNext = '0;
    cmdNext.data = dataQ;
    if (strobeQ) begin
      case (codeQ)
        aprPkg::condSelEn:      cmdNext.selEn = 1'b1;
        aprPkg::condSelDis:     cmdNext.selDis = 1'b1;
        aprPkg::condSelSet:     cmdNext.selSet = 1'b1;
        aprPkg::condSelClr:     cmdNext.selClr = 1'b1;
        aprPkg::condLoadBlocks: cmdNext.loadBlocks = 1'b1;
        aprPkg::condReadDiag:   cmdNext.readDiag = 1'b1;
        default: ;
      endcase
    end
  end

  // Second stage holds the decoded strobe for exactly one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd <= '0;
    end else begin
      cmd <= cmdNext;
    end
  end

  // Diag select follows the strobe so it lines up with readDiag
  always_ff @(posedge clk) begin
    diagSelReg <= diagSelQ;
  end

  assign strobes = {cmd.selEn, cmd.selDis, cmd.selSet,
                    cmd.selClr, cmd.loadBlocks, cmd.readDiag};

  // A strobe only ever comes from a bus strobe one cycle earlier
  cmdOneHot: assert property (@(posedge clk) disable iff (reset)
    (|strobes) |-> $onehot(strobes) && $past(strobeQ))
    else $error("command strobes not one-hot or without a bus strobe");

endmodule

/* rtl/aprErrorFlags.sv */
`timescale 1ns/100ps

module aprErrorFlags #(
  parameter aprPkg::aprFlagsT ErrorMask = 8'h2a
) (
  input  logic             clk,
  input  logic             reset,
  input  aprPkg::aprCmdT   cmd,
  input  aprPkg::aprFlagsT eventPulse,
  input  logic             sweepBusy,
  output aprPkg::aprFlagsT flags,
  output aprPkg::aprFlagsT intEnables,
  output logic             interrupt,
  output logic             anyError
);

  logic             sweepBusyQ;
  aprPkg::aprFlagsT eventIn;
  aprPkg::aprFlagsT eventQ;
  aprPkg::aprFlagsT cmdMask;
  aprPkg::aprFlagsT flagsNext;
  aprPkg::aprFlagsT enablesNext;

  // Sweep done replaces the unused top event bit
  always_comb begin
    eventIn = eventPulse;
    eventIn[aprPkg::flagSweepDone] = sweepBusyQ & ~sweepBusy;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sweepBusyQ <= 1'b0;
      eventQ     <= '0;
    end else begin
      sweepBusyQ <= sweepBusy;
      eventQ     <= eventIn;
    end
  end

  assign cmdMask = cmd.data[7:0];

  always_comb begin
    flagsNext = flags;
    if (cmd.selClr) begin
      flagsNext = flagsNext & ~cmdMask;
    end
    if (cmd.selSet) begin
      flagsNext = flagsNext | cmdMask;
    end
    // Events go in last so they beat a clear in the same cycle
    flagsNext = flagsNext | eventQ;
  end

  always_comb begin
    enablesNext = intEnables;
    if (cmd.selEn) begin
      enablesNext = enablesNext | cmdMask;
    end
    if (cmd.selDis) begin
      enablesNext = enablesNext & ~cmdMask;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags      <= '0;
      intEnables <= '0;
      anyError   <= 1'b0;
    end else begin
      flags      <= flagsNext;
      intEnables <= enablesNext;
      // Only reset clears this sticky flag
      anyError   <= anyError | (|(flagsNext & ErrorMask));
    end
  end

  assign interrupt = |(flags & intEnables);

endmodule

/* rtl/aprAcBlocks.sv */
`timescale 1ns/100ps

module aprAcBlocks (
  input  logic              clk,
  input  logic              reset,
  input  aprPkg::aprCmdT    cmd,
  input  aprPkg::aprAcT     acField,
  input  aprPkg::aprAcT     magic,
  input  aprPkg::aprAcT     xrField,
  input  aprPkg::aprAcT     vmaField,
  input  aprPkg::aprBlockT  magicBlock,
  input  aprPkg::aprFmSelT  fmSel,
  input  logic              xrPrevious,
  output aprPkg::aprBlockT  currentBlock,
  output aprPkg::aprBlockT  previousBlock,
  output aprPkg::aprFmAddrT fmAddr
);

  localparam int BlockBits = $bits(aprPkg::aprBlockT);

  aprPkg::aprAcT    acPlus1;
  aprPkg::aprAcT    acPlus2;
  aprPkg::aprAcT    acPlus3;
  aprPkg::aprAcT    acPlusMagic;
  aprPkg::aprBlockT xrBlock;
  aprPkg::aprBlockT addrBlock;
  aprPkg::aprAcT    addrAc;

  always_ff @(posedge clk) begin
    if (reset) begin
      currentBlock  <= '0;
      previousBlock <= '0;
    end else if (cmd.loadBlocks) begin
      currentBlock  <= cmd.data[aprPkg::dataCurBlockLsb +: BlockBits];
      previousBlock <= cmd.data[aprPkg::dataPrevBlockLsb +: BlockBits];
    end
  end

  // All sums wrap within the 16 ACs of a block
  assign acPlus1     = acField + 4'd1;
  assign acPlus2     = acField + 4'd2;
  assign acPlus3     = acField + 4'd3;
  assign acPlusMagic = acField + magic;

  assign xrBlock = xrPrevious ? previousBlock : currentBlock;

  always_comb begin
    addrBlock = currentBlock;
    case (fmSel)
      aprPkg::fmAc:          addrAc = acField;
      aprPkg::fmAcPlus1:     addrAc = acPlus1;
      aprPkg::fmXr: begin
        addrBlock = xrBlock;
        addrAc    = xrField;
      end
      aprPkg::fmVma:         addrAc = vmaField;
      aprPkg::fmAcPlus2:     addrAc = acPlus2;
      aprPkg::fmAcPlus3:     addrAc = acPlus3;
      aprPkg::fmAcPlusMagic: addrAc = acPlusMagic;
      default: begin
        addrBlock = magicBlock;
        addrAc    = magic;
      end
    endcase
  end

  assign fmAddr = {addrBlock, addrAc};

  // Blocks only move on a loadBlocks strobe
  blockStable: assert property (@(posedge clk) disable iff (reset)
    !cmd.loadBlocks |=> $stable(currentBlock) && $stable(previousBlock))
    else $error("AC block registers changed without loadBlocks");

endmodule

/* rtl/aprDiagRead.sv */
`timescale 1ns/100ps

module aprDiagRead #(
  parameter int DiagWidth = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 readDiag,
  input  aprPkg::aprDiagSelT   diagSel,
  input  aprPkg::aprFlagsT     flags,
  input  aprPkg::aprFlagsT     intEnables,
  input  aprPkg::aprBlockT     currentBlock,
  input  aprPkg::aprBlockT     previousBlock,
  input  logic                 anyError,
  input  logic                 interrupt,
  output logic [DiagWidth-1:0] diagWord,
  output logic                 diagValid
);

  logic [DiagWidth-1:0] groupWord;

  always_comb begin
    case (diagSel)
      2'd0:    groupWord = DiagWidth'(flags);
      2'd1:    groupWord = DiagWidth'(intEnables);
      // Block status with the current block in the top bits
      2'd2:    groupWord = DiagWidth'({currentBlock, previousBlock, anyError, interrupt});
      default: groupWord = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      diagValid <= 1'b0;
      diagWord  <= '0;
    end else begin
      diagValid <= readDiag;
      if (readDiag) begin
        diagWord <= groupWord;
      end
    end
  end

endmodule

/* rtl/apr.sv */
`timescale 1ns/100ps

module apr #(
  parameter aprPkg::aprFlagsT ErrorMask = aprPkg::aprFlagsT'((1 << aprPkg::flagNxm) |
                                                            (1 << aprPkg::flagMemPar) |
                                                            (1 << aprPkg::flagAdrPar)),
  parameter int DiagWidth = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 condStrobe,
  input  aprPkg::aprCondT      condCode,
  input  aprPkg::aprDataT      condData,
  input  aprPkg::aprFlagsT     eventPulse,
  input  logic                 sweepBusy,
  input  aprPkg::aprAcT        acField,
  input  aprPkg::aprAcT        magic,
  input  aprPkg::aprBlockT     magicBlock,
  input  aprPkg::aprAcT        xrField,
  input  aprPkg::aprAcT        vmaField,
  input  aprPkg::aprFmSelT     fmSel,
  input  logic                 xrPrevious,
  input  aprPkg::aprDiagSelT   diagSel,
  output logic                 interrupt,
  output aprPkg::aprFmAddrT    fmAddr,
  output logic [DiagWidth-1:0] diagWord,
  output logic                 diagValid
);

  aprPkg::aprCmdT     cmd;
  aprPkg::aprDiagSelT diagSelReg;
  aprPkg::aprFlagsT   flags;
  aprPkg::aprFlagsT   intEnables;
  logic               anyError;
  aprPkg::aprBlockT   currentBlock;
  aprPkg::aprBlockT   previousBlock;

  aprCommandDecode uDecode (
    .clk       (clk),
    .reset     (reset),
    .condStrobe(condStrobe),
    .condCode  (condCode),
    .condData  (condData),
    .diagSel   (diagSel),
    .cmd       (cmd),
    .diagSelReg(diagSelReg)
  );

  aprErrorFlags #(
    .ErrorMask(ErrorMask)
  ) uFlags (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .eventPulse(eventPulse),
    .sweepBusy (sweepBusy),
    .flags     (flags),
    .intEnables(intEnables),
    .interrupt (interrupt),
    .anyError  (anyError)
  );

  aprAcBlocks uBlocks (
    .clk          (clk),
    .reset        (reset),
    .cmd          (cmd),
    .acField      (acField),
    .magic        (magic),
    .xrField      (xrField),
    .vmaField     (vmaField),
    .magicBlock   (magicBlock),
    .fmSel        (fmSel),
    .xrPrevious   (xrPrevious),
    .currentBlock (currentBlock),
    .previousBlock(previousBlock),
    .fmAddr       (fmAddr)
  );

  aprDiagRead #(
    .DiagWidth(DiagWidth)
  ) uDiag (
    .clk          (clk),
    .reset        (reset),
    .readDiag     (cmd.readDiag),
    .diagSel      (diagSelReg),
    .flags        (flags),
    .intEnables   (intEnables),
    .currentBlock (currentBlock),
    .previousBlock(previousBlock),
    .anyError     (anyError),
    .interrupt    (interrupt),
    .diagWord     (diagWord),
    .diagValid    (diagValid)
  );

endmodule

/* testbench/aprModel.svh */
`ifndef APR_MODEL_SVH
`define APR_MODEL_SVH

// Bus capture stage
logic               mStrobe1;
aprPkg::aprCondT    mCode1;
aprPkg::aprDataT    mData1;
aprPkg::aprDiagSelT mSel1;

// Decoded command stage
logic               mCmd2;
aprPkg::aprCondT    mCode2;
aprPkg::aprDataT    mData2;
aprPkg::aprDiagSelT mSel2;

aprPkg::aprFlagsT   mEvent1;
logic               mSweepPrev;
aprPkg::aprFlagsT   mFlags;
aprPkg::aprFlagsT   mEnables;
aprPkg::aprBlockT   mCur;
aprPkg::aprBlockT   mPrev;
logic               mAnyError;
logic [7:0]         mDiagWord;
logic               mDiagValid;

task automatic clearModel();
  mStrobe1   = 1'b0;
  mCode1     = aprPkg::condSelEn;
  mData1     = '0;
  mSel1      = '0;
  mCmd2      = 1'b0;
  mCode2     = aprPkg::condSelEn;
  mData2     = '0;
  mSel2      = '0;
  mEvent1    = '0;
  mSweepPrev = 1'b0;
  mFlags     = '0;
  mEnables   = '0;
  mCur       = '0;
  mPrev      = '0;
  mAnyError  = 1'b0;
  mDiagWord  = '0;
  mDiagValid = 1'b0;
endtask

function automatic logic pendingInterrupt();
  return |(mFlags & mEnables);
endfunction

function automatic logic [7:0] diagGroup(input aprPkg::aprDiagSelT sel);
  case (sel)
    2'd0:    return mFlags;
    2'd1:    return mEnables;
    2'd2:    return {mCur, mPrev, mAnyError, pendingInterrupt()};
    default: return 8'h00;
  endcase
endfunction

function automatic aprPkg::aprFmAddrT fastMemAddr(input aprPkg::aprFmSelT sel,
    input aprPkg::aprAcT ac, input aprPkg::aprAcT mg, input aprPkg::aprBlockT mgBlock,
    input aprPkg::aprAcT xr, input aprPkg::aprAcT vma, input logic xrPrev);
  aprPkg::aprBlockT blk;
  int               acNum;
  blk = mCur;
  case (sel)
    aprPkg::fmAc:          acNum = ac;
    aprPkg::fmAcPlus1:     acNum = ac + 1;
    aprPkg::fmXr: begin
      acNum = xr;
      if (xrPrev) begin
        blk = mPrev;
      end
    end
    aprPkg::fmVma:         acNum = vma;
    aprPkg::fmAcPlus2:     acNum = ac + 2;
    aprPkg::fmAcPlus3:     acNum = ac + 3;
    aprPkg::fmAcPlusMagic: acNum = ac + mg;
    default: begin
      acNum = mg;
      blk   = mgBlock;
    end
  endcase
  return {blk, 4'(acNum % 16)};
endfunction

// One rising edge with the inputs as sampled at that edge
task automatic stepModel(input logic strobe, input aprPkg::aprCondT code,
    input aprPkg::aprDataT data, input aprPkg::aprDiagSelT sel,
    input aprPkg::aprFlagsT events, input logic sweep);
  aprPkg::aprFlagsT newFlags;
  aprPkg::aprFlagsT mask;
  newFlags   = mFlags;
  mask       = mData2[7:0];
  mDiagValid = 1'b0;
  if (mCmd2) begin
    case (mCode2)
      aprPkg::condSelEn:  mEnables = mEnables | mask;
      aprPkg::condSelDis: mEnables = mEnables & ~mask;
      aprPkg::condSelSet: newFlags = newFlags | mask;
      aprPkg::condSelClr: newFlags = newFlags & ~mask;
      aprPkg::condLoadBlocks: begin
        mCur  = mData2[10:8];
        mPrev = mData2[13:11];
      end
      aprPkg::condReadDiag: begin
        mDiagWord  = diagGroup(mSel2);
        mDiagValid = 1'b1;
      end
      default: ;
    endcase
  end
  // Events win over a clear
  newFlags  = newFlags | mEvent1;
  mFlags    = newFlags;
  mAnyError = mAnyError | newFlags[1] | newFlags[3] | newFlags[5];
  mCmd2      = mStrobe1 && (mCode1 <= aprPkg::condReadDiag);
  mCode2     = mCode1;
  mData2     = mData1;
  mSel2      = mSel1;
  mStrobe1   = strobe;
  mCode1     = code;
  mData1     = data;
  mSel1      = sel;
  mEvent1    = {mSweepPrev & ~sweep, events[6:0]};
  mSweepPrev = sweep;
endtask

`endif

/* testbench/aprTb.sv */
`timescale 1ns/100ps

module aprTb;

  localparam int ClkPeriod = 40;
  localparam int ResetCycles = 16;
  localparam int NumStrobes = 400;
  localparam int MaxCycles = 2 * ResetCycles + 4 * NumStrobes + 200;

  logic               clk;
  logic               reset;
  logic               condStrobe;
  aprPkg::aprCondT    condCode;
  aprPkg::aprDataT    condData;
  aprPkg::aprFlagsT   eventPulse;
  logic               sweepBusy;
  aprPkg::aprAcT      acField;
  aprPkg::aprAcT      magic;
  aprPkg::aprBlockT   magicBlock;
  aprPkg::aprAcT      xrField;
  aprPkg::aprAcT      vmaField;
  aprPkg::aprFmSelT   fmSel;
  logic               xrPrevious;
  aprPkg::aprDiagSelT diagSel;
  logic               interrupt;
  aprPkg::aprFmAddrT  fmAddr;
  logic [7:0]         diagWord;
  logic               diagValid;

  integer seed;
  logic   randomEvents;

  `include "aprModel.svh"

  apr u_dut (
    .clk       (clk),
    .reset     (reset),
    .condStrobe(condStrobe),
    .condCode  (condCode),
    .condData  (condData),
    .eventPulse(eventPulse),
    .sweepBusy (sweepBusy),
    .acField   (acField),
    .magic     (magic),
    .magicBlock(magicBlock),
    .xrField   (xrField),
    .vmaField  (vmaField),
    .fmSel     (fmSel),
    .xrPrevious(xrPrevious),
    .diagSel   (diagSel),
    .interrupt (interrupt),
    .fmAddr    (fmAddr),
    .diagWord  (diagWord),
    .diagValid (diagValid)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s mismatch, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Advance the model at the edge, then move to the drive point
  task automatic tick();
    @(posedge clk);
    if (reset) begin
      clearModel();
    end else begin
      stepModel(condStrobe, condCode, condData, diagSel, eventPulse, sweepBusy);
    end
    #5;
  endtask

  task automatic driveBackground();
    fmSel      = aprPkg::aprFmSelT'(3'($random(seed)));
    acField    = 4'($random(seed));
    magic      = 4'($random(seed));
    magicBlock = 3'($random(seed));
    xrField    = 4'($random(seed));
    vmaField   = 4'($random(seed));
    xrPrevious = 1'($random(seed));
    eventPulse = '0;
    if (randomEvents) begin
      if (($random(seed) & 7) == 0) begin
        eventPulse = aprPkg::aprFlagsT'(1 << ($random(seed) & 7));
      end
      if (($random(seed) & 3) == 0) begin
        sweepBusy = ~sweepBusy;
      end
    end
  endtask

  task automatic settleAndCheck();
    @(negedge clk);
    if (!reset) begin
      checkValue(interrupt, pendingInterrupt(), "interrupt");
      checkValue(fmAddr, fastMemAddr(fmSel, acField, magic, magicBlock, xrField,
                                     vmaField, xrPrevious), "fmAddr");
      checkValue(diagValid, mDiagValid, "diagValid");
      checkValue(diagWord, mDiagWord, "diagWord");
    end
  endtask

  task automatic cycle(input logic strobe, input aprPkg::aprCondT code,
                       input aprPkg::aprDataT data, input aprPkg::aprDiagSelT sel);
    tick();
    condStrobe = strobe;
    condCode   = code;
    condData   = data;
    diagSel    = sel;
    driveBackground();
    settleAndCheck();
  endtask

  // Code and data toggle without a strobe
  task automatic idle();
    cycle(1'b0, aprPkg::aprCondT'(3'($random(seed))), 18'($random(seed)),
          2'($random(seed)));
  endtask

  task automatic eventCycle(input aprPkg::aprFlagsT events, input logic sweep);
    tick();
    condStrobe = 1'b0;
    driveBackground();
    eventPulse = events;
    sweepBusy  = sweep;
    settleAndCheck();
  endtask

  task automatic readGroup(input aprPkg::aprDiagSelT sel, output logic [7:0] word);
    int waitCycles;
    cycle(1'b1, aprPkg::condReadDiag, '0, sel);
    waitCycles = 0;
    idle();
    while (!diagValid && waitCycles < 4) begin
      idle();
      waitCycles++;
    end
    checkValue(diagValid, 1'b1, "diagValid never arrived for a diag read");
    word = diagWord;
  endtask

  task automatic applyReset();
    tick();
    reset      = 1'b1;
    condStrobe = 1'b0;
    repeat (ResetCycles) begin
      tick();
    end
    reset = 1'b0;
    settleAndCheck();
  endtask

  initial begin
    #(MaxCycles * ClkPeriod);
    $display("Timeout: the run did not finish within %0d clock cycles", MaxCycles);
    $display("TESTBENCH FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    logic [7:0] word;
    seed         = 87;
    randomEvents = 1'b0;
    clk          = 1'b0;
    reset        = 1'b1;
    condStrobe   = 1'b0;
    condCode     = aprPkg::condSelEn;
    condData     = '0;
    eventPulse   = '0;
    sweepBusy    = 1'b0;
    acField      = '0;
    magic        = '0;
    magicBlock   = '0;
    xrField      = '0;
    vmaField     = '0;
    fmSel        = aprPkg::fmAc;
    xrPrevious   = 1'b0;
    diagSel      = '0;
    clearModel();
    applyReset();

    checkValue(diagValid, 1'b0, "diagValid after reset");
    for (int g = 0; g < 3; g++) begin
      readGroup(2'(g), word);
      checkValue(word, 8'h00, "diag group after reset");
    end

    // Event on bit 2 lands with its clear and sweep falls after
    cycle(1'b1, aprPkg::condSelEn, 18'h00084, 2'd0);
    cycle(1'b1, aprPkg::condSelClr, 18'h00004, 2'd0);
    eventCycle(8'h04, 1'b1);
    eventCycle(8'h00, 1'b0);
    idle();
    readGroup(2'd0, word);
    checkValue(word[2], 1'b1, "event over clear");
    checkValue(word[7], 1'b1, "sweep done flag");
    checkValue(interrupt, 1'b1, "interrupt from enabled flag");

    // Current block 5 and previous block 3
    cycle(1'b1, aprPkg::condLoadBlocks, 18'h01d00, 2'd0);
    readGroup(2'd2, word);
    checkValue(word, 8'had, "group 2 after loadBlocks");

    // Memory parity set then cleared
    cycle(1'b1, aprPkg::condSelSet, 18'h00008, 2'd0);
    cycle(1'b1, aprPkg::condSelClr, 18'h000ff, 2'd0);
    readGroup(2'd2, word);
    checkValue(word, 8'hae, "group 2 with sticky anyError");

    randomEvents = 1'b1;
    for (int i = 0; i < NumStrobes; i++) begin
      cycle(1'b1, aprPkg::aprCondT'(3'($random(seed))), 18'($random(seed)),
            2'($random(seed)));
      repeat ($random(seed) & 3) begin
        idle();
      end
    end
    randomEvents = 1'b0;
    readGroup(2'd2, word);
    checkValue(word[1], 1'b1, "anyError held until reset");

    applyReset();
    readGroup(2'd2, word);
    checkValue(word, 8'h00, "group 2 after second reset");

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+testbench
rtl/aprPkg.sv
rtl/aprCommandDecode.sv
rtl/aprErrorFlags.sv
rtl/aprAcBlocks.sv
rtl/aprDiagRead.sv
rtl/apr.sv
testbench/aprTb.sv
